//--- hdl/matrix_bank_pkg.sv
// Sizes are fixed here. A descriptor needs 1..MAX_ROWS rows and 1..MAX_COLUMNS columns
package matrix_bank_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------

  localparam int MAX_ROWS      = 8;
  localparam int MAX_COLUMNS   = 16;
  localparam int BEAT_FEATURES = 4;
  localparam int FEATURE_WIDTH = 32;
  localparam int ADDR_WIDTH    = 32;
  localparam int BEAT_WIDTH    = BEAT_FEATURES * FEATURE_WIDTH;

  // ------------------------------
  // Vector types
  // ------------------------------

  typedef logic [FEATURE_WIDTH-1:0] feature_t;
  typedef logic [ADDR_WIDTH-1:0]    addr_t;

  // Feature 0 of a beat sits in the top 32 bits
  typedef logic [BEAT_WIDTH-1:0] beat_t;

  // Counts run 0..MAX_COLUMNS, so one extra bit
  typedef logic [$clog2(MAX_COLUMNS):0] dim_t;
  typedef logic [$clog2(MAX_ROWS)-1:0]  row_idx_t;

  // Longest row fetch is MAX_COLUMNS * 4 bytes
  typedef logic [$clog2(MAX_COLUMNS * FEATURE_WIDTH / 8):0] byte_count_t;

  typedef logic [MAX_ROWS-1:0] row_mask_t;

  // ------------------------------
  // Payloads
  // ------------------------------

  typedef struct packed {
    addr_t start_address;
    dim_t  columns;
    dim_t  rows;
  } matrix_req_t;

  typedef struct packed {
    addr_t       start_address;
    byte_count_t byte_count;
  } fetch_req_t;

  // One lane per row buffer, lane r carries row r
  typedef struct packed {
    feature_t [MAX_ROWS-1:0] data;
    row_mask_t               valid_mask;
    logic                    done;
  } row_resp_t;

  // ------------------------------
  // State machines
  // ------------------------------

  typedef enum logic [2:0] {
    IDLE,
    FETCH_REQ,
    WAIT_RESP,
    WRITE,
    LOADED
  } fetch_state_e;

  typedef enum logic {
    WAITING,
    DUMP
  } dump_state_e;

endpackage

//--- hdl/matrix_fetch_ctrl.sv
// ROW_ALIGN_BYTES must be a power of two; rows and columns must be nonzero; reload needs a reset
`timescale 1ns/1ns

module matrix_fetch_ctrl
  import matrix_bank_pkg::*;
#(
  parameter int ROW_ALIGN_BYTES = 64
) (
  input  logic        core_clk,
  input  logic        resetn,
  // Descriptor
  input  logic        matrix_req_valid,
  output logic        matrix_req_ready,
  input  matrix_req_t matrix_req,
  output logic        matrix_resp_valid,
  // Read master
  output logic        fetch_req_valid,
  input  logic        fetch_req_ready,
  output fetch_req_t  fetch_req,
  input  logic        fetch_resp_valid,
  output logic        fetch_resp_ready,
  input  beat_t       fetch_resp_data,
  // Row storage
  output logic        push,
  output row_idx_t    push_row,
  output feature_t    push_feature,
  // Dump side
  output logic        loaded,
  output dim_t        row_length
);

  localparam int FEATURE_BYTES = FEATURE_WIDTH / 8;
  localparam int OFFSET_WIDTH  = $clog2(BEAT_FEATURES);

  typedef logic [OFFSET_WIDTH-1:0] offset_t;

  fetch_state_e state, state_next;
  matrix_req_t  req_q;

  addr_t       row_addr;
  addr_t       row_stride;
  byte_count_t row_bytes;
  dim_t        row_beats;

  dim_t     rows_fetched;
  dim_t     beats_left;
  row_idx_t cur_row;
  offset_t  feature_offset;
  logic     last_feature;
  logic     fetch_accept;
  logic     beat_accept;

  feature_t [BEAT_FEATURES-1:0] beat_q;

  // ------------------------------
  // Row geometry
  // ------------------------------

  assign row_bytes = byte_count_t'(req_q.columns * FEATURE_BYTES);

  // Stride rounded up to the alignment boundary
  assign row_stride = (addr_t'(row_bytes) + addr_t'(ROW_ALIGN_BYTES - 1)) &
                      ~addr_t'(ROW_ALIGN_BYTES - 1);

  assign row_beats  = dim_t'((req_q.columns + BEAT_FEATURES - 1) / BEAT_FEATURES);
  assign row_length = dim_t'(row_beats * BEAT_FEATURES);

  // ------------------------------
  // State machine
  // ------------------------------

  assign fetch_accept = fetch_req_valid && fetch_req_ready;
  assign beat_accept  = fetch_resp_valid && fetch_resp_ready;
  assign last_feature = (feature_offset == offset_t'(BEAT_FEATURES - 1));

  always_ff @(posedge core_clk or negedge resetn) begin
    if (!resetn) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:      if (matrix_req_valid) state_next = FETCH_REQ;
      FETCH_REQ: if (fetch_req_ready) state_next = WAIT_RESP;
      WAIT_RESP: if (fetch_resp_valid) state_next = WRITE;
      WRITE: begin
        if (last_feature) begin
          if (beats_left != '0) begin
            state_next = WAIT_RESP;
          end else if (rows_fetched == req_q.rows) begin
            state_next = LOADED;
          end else begin
            state_next = FETCH_REQ;
          end
        end
      end
      LOADED:    state_next = LOADED;
      default:   state_next = IDLE;
    endcase
  end

  // ------------------------------
  // Descriptor and fetch counters
  // ------------------------------

  always_ff @(posedge core_clk or negedge resetn) begin
    if (!resetn) begin
      req_q    <= '0;
      row_addr <= '0;
    end else if (matrix_req_valid && matrix_req_ready) begin
      req_q    <= matrix_req;
      row_addr <= matrix_req.start_address;
    end else if (fetch_accept) begin
      row_addr <= row_addr + row_stride;
    end
  end

  always_ff @(posedge core_clk or negedge resetn) begin
    if (!resetn) begin
      rows_fetched <= '0;
      beats_left   <= '0;
      cur_row      <= '0;
    end else if (fetch_accept) begin
      rows_fetched <= rows_fetched + 1'b1;
      beats_left   <= row_beats;
      cur_row      <= row_idx_t'(rows_fetched);
    end else if (beat_accept) begin
      beats_left <= beats_left - 1'b1;
    end
  end

  // ------------------------------
  // Beat unpacking
  // ------------------------------

  always_ff @(posedge core_clk) begin
    if (beat_accept) begin
      beat_q <= fetch_resp_data;
    end
  end

  // Wraps back to 0 after the last feature of a beat
  always_ff @(posedge core_clk or negedge resetn) begin
    if (!resetn) begin
      feature_offset <= '0;
    end else if (state == WRITE) begin
      feature_offset <= feature_offset + 1'b1;
    end
  end

  assign push         = (state == WRITE);
  assign push_row     = cur_row;
  assign push_feature = beat_q[BEAT_FEATURES - 1 - int'(feature_offset)];

  assign matrix_req_ready  = (state == IDLE);
  assign fetch_req_valid   = (state == FETCH_REQ);
  assign fetch_resp_ready  = (state == WAIT_RESP);
  assign fetch_req.start_address = row_addr;
  assign fetch_req.byte_count    = row_bytes;

  // Last feature of the final beat of the final row
  assign matrix_resp_valid = push && last_feature && (beats_left == '0) &&
                             (rows_fetched == req_q.rows);
  assign loaded = (state == LOADED);

endmodule

//--- hdl/row_store.sv
// Each row holds at most MAX_COLUMNS features; rows are filled once per reset
`timescale 1ns/1ns

module row_store
  import matrix_bank_pkg::*;
(
  input  logic                    core_clk,
  input  logic                    resetn,
  // Write side
  input  logic                    push,
  input  row_idx_t                push_row,
  input  feature_t                push_feature,
  // Read side
  input  row_mask_t               pop,
  input  logic                    rewind,
  output feature_t [MAX_ROWS-1:0] head_data,
  output row_mask_t               empty
);

  localparam int COL_IDX_WIDTH = $clog2(MAX_COLUMNS);

  // ------------------------------
  // One buffer per matrix row
  // ------------------------------

  for (genvar r = 0; r < MAX_ROWS; r++) begin : g_row

    feature_t mem [MAX_COLUMNS];
    dim_t     wr_ptr;
    dim_t     rd_ptr;
    logic     row_push;
    logic     row_pop;

    assign row_push = push && (push_row == row_idx_t'(r));

    // Pops on an empty row are ignored
    assign row_pop = pop[r] && !empty[r];

    always_ff @(posedge core_clk) begin
      if (row_push) begin
        mem[wr_ptr[COL_IDX_WIDTH-1:0]] <= push_feature;
      end
    end

    always_ff @(posedge core_clk or negedge resetn) begin
      if (!resetn) begin
        wr_ptr <= '0;
      end else if (row_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end

    // Rewind keeps the contents, so the same row reads out again
    always_ff @(posedge core_clk or negedge resetn) begin
      if (!resetn) begin
        rd_ptr <= '0;
      end else if (rewind) begin
        rd_ptr <= '0;
      end else if (row_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end

    assign head_data[r] = mem[rd_ptr[COL_IDX_WIDTH-1:0]];
    assign empty[r]     = (rd_ptr == wr_ptr);

  end

endmodule

//--- hdl/diagonal_dump.sv
// Row r lags row 0 by r responses; row_length must be nonzero once loaded is high
`timescale 1ns/1ns

module diagonal_dump
  import matrix_bank_pkg::*;
(
  input  logic                    core_clk,
  input  logic                    resetn,
  // From fetch control
  input  logic                    loaded,
  input  dim_t                    row_length,
  // Row channel
  input  logic                    row_req_valid,
  output logic                    row_req_ready,
  output logic                    row_resp_valid,
  input  logic                    row_resp_ready,
  output row_resp_t               row_resp,
  // Row storage
  input  feature_t [MAX_ROWS-1:0] head_data,
  input  row_mask_t               empty,
  output row_mask_t               pop,
  output logic                    rewind
);

  dump_state_e state, state_next;

  row_mask_t shift;
  row_mask_t valid_mask;
  dim_t      step;
  dim_t      step_next;
  logic      start;
  logic      accept;
  logic      done;

  // ------------------------------
  // Handshakes
  // ------------------------------

  assign row_req_ready  = loaded && (state == WAITING);
  assign start          = row_req_valid && row_req_ready;
  assign row_resp_valid = (state == DUMP);
  assign accept         = row_resp_valid && row_resp_ready;

  always_ff @(posedge core_clk or negedge resetn) begin
    if (!resetn) begin
      state <= WAITING;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      WAITING: if (start) state_next = DUMP;
      DUMP:    if (accept && done) state_next = WAITING;
      default: state_next = WAITING;
    endcase
  end

  // ------------------------------
  // Wavefront
  // ------------------------------

  // Step count saturates at row_length, the head is active below it
  assign step_next = (step == row_length) ? step : step + 1'b1;

  always_ff @(posedge core_clk or negedge resetn) begin
    if (!resetn) begin
      shift <= '0;
      step  <= '0;
    end else if (start) begin
      shift <= row_mask_t'(1);
      step  <= '0;
    end else if (accept) begin
      shift <= {shift[MAX_ROWS-2:0], step_next < row_length};
      step  <= step_next;
    end
  end

  // Rows past the matrix never fill, so the empty flags trim them
  assign valid_mask = shift & ~empty;
  assign done       = (valid_mask == '0);

  always_comb begin
    for (int r = 0; r < MAX_ROWS; r++) begin
      row_resp.data[r] = valid_mask[r] ? head_data[r] : '0;
    end
    row_resp.valid_mask = valid_mask;
    row_resp.done       = done;
  end

  assign pop    = accept ? valid_mask : '0;
  assign rewind = accept && done;

endmodule

//--- hdl/matrix_bank.sv
// Loads one matrix per reset, then replays it on every row channel request
`timescale 1ns/1ns

module matrix_bank
  import matrix_bank_pkg::*;
#(
  parameter int ROW_ALIGN_BYTES = 64
) (
  input  logic        core_clk,
  input  logic        resetn,
  // Descriptor
  input  logic        matrix_req_valid,
  output logic        matrix_req_ready,
  input  matrix_req_t matrix_req,
  output logic        matrix_resp_valid,
  // Read master
  output logic        fetch_req_valid,
  input  logic        fetch_req_ready,
  output fetch_req_t  fetch_req,
  input  logic        fetch_resp_valid,
  output logic        fetch_resp_ready,
  input  beat_t       fetch_resp_data,
  // Row channel
  input  logic        row_req_valid,
  output logic        row_req_ready,
  output logic        row_resp_valid,
  input  logic        row_resp_ready,
  output row_resp_t   row_resp
);

  logic                    push;
  row_idx_t                push_row;
  feature_t                push_feature;
  logic                    loaded;
  dim_t                    row_length;
  row_mask_t               pop;
  logic                    rewind;
  feature_t [MAX_ROWS-1:0] head_data;
  row_mask_t               empty;

  // ------------------------------
  // Fetch, store, dump
  // ------------------------------

  matrix_fetch_ctrl #(
    .ROW_ALIGN_BYTES (ROW_ALIGN_BYTES)
  ) u_fetch_ctrl (
    .core_clk          (core_clk),
    .resetn            (resetn),
    .matrix_req_valid  (matrix_req_valid),
    .matrix_req_ready  (matrix_req_ready),
    .matrix_req        (matrix_req),
    .matrix_resp_valid (matrix_resp_valid),
    .fetch_req_valid   (fetch_req_valid),
    .fetch_req_ready   (fetch_req_ready),
    .fetch_req         (fetch_req),
    .fetch_resp_valid  (fetch_resp_valid),
    .fetch_resp_ready  (fetch_resp_ready),
    .fetch_resp_data   (fetch_resp_data),
    .push              (push),
    .push_row          (push_row),
    .push_feature      (push_feature),
    .loaded            (loaded),
    .row_length        (row_length)
  );

  row_store u_row_store (
    .core_clk     (core_clk),
    .resetn       (resetn),
    .push         (push),
    .push_row     (push_row),
    .push_feature (push_feature),
    .pop          (pop),
    .rewind       (rewind),
    .head_data    (head_data),
    .empty        (empty)
  );

  diagonal_dump u_dump (
    .core_clk       (core_clk),
    .resetn         (resetn),
    .loaded         (loaded),
    .row_length     (row_length),
    .row_req_valid  (row_req_valid),
    .row_req_ready  (row_req_ready),
    .row_resp_valid (row_resp_valid),
    .row_resp_ready (row_resp_ready),
    .row_resp       (row_resp),
    .head_data      (head_data),
    .empty          (empty),
    .pop            (pop),
    .rewind         (rewind)
  );

endmodule

//--- verification/axi_read_model.sv
// Serves one fetch at a time with ceil(byte_count/16) beats of pattern data and random stalls
`timescale 1ns/1ns

module axi_read_model
  import matrix_bank_pkg::*;
(
  input  logic       core_clk,
  input  logic       resetn,
  input  logic       fetch_req_valid,
  output logic       fetch_req_ready,
  input  fetch_req_t fetch_req,
  output logic       fetch_resp_valid,
  input  logic       fetch_resp_ready,
  output beat_t      fetch_resp_data
);

  logic [31:0] rng;
  addr_t       burst_addr;
  int          beats_left;
  logic        beat_taken;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory contents as a function of the byte address
  function automatic feature_t pattern(input addr_t a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
  endfunction

  // Feature 0 goes to the top lane
  function automatic beat_t beat_at(input addr_t a);
    beat_t b;
    for (int k = 0; k < BEAT_FEATURES; k++) begin
      b[BEAT_WIDTH - 1 - FEATURE_WIDTH * k -: FEATURE_WIDTH] = pattern(a + addr_t'(4 * k));
    end
    return b;
  endfunction

  initial begin
    rng              = 32'h0793ade7;
    burst_addr       = '0;
    beats_left       = 0;
    beat_taken       = 1'b0;
    fetch_req_ready  = 1'b0;
    fetch_resp_valid = 1'b0;
    fetch_resp_data  = '0;
  end

  // Transfers seen at the rising edge
  always @(posedge core_clk) begin
    beat_taken = resetn && fetch_resp_valid && fetch_resp_ready;
    if (!resetn) begin
      beats_left = 0;
    end else if (fetch_req_valid && fetch_req_ready) begin
      burst_addr = fetch_req.start_address;
      beats_left = (fetch_req.byte_count + BEAT_WIDTH / 8 - 1) / (BEAT_WIDTH / 8);
    end else if (beat_taken) begin
      burst_addr = burst_addr + addr_t'(BEAT_WIDTH / 8);
      beats_left = beats_left - 1;
    end
  end

  // A beat once offered is held until it is taken
  always @(negedge core_clk) begin
    rng = lcg_next(rng);
    if (!resetn) begin
      fetch_req_ready  = 1'b0;
      fetch_resp_valid = 1'b0;
    end else begin
      fetch_req_ready = (beats_left == 0) && rng[31];
      if (!fetch_resp_valid || beat_taken) begin
        fetch_resp_valid = (beats_left != 0) && rng[29];
        fetch_resp_data  = beat_at(burst_addr);
      end
    end
  end

endmodule

//--- verification/matrix_bank_tb.sv
// Two matrix shapes, each loaded after a reset, dumped once and replayed; stops at the first error
`timescale 1ns/1ns

module matrix_bank_tb
  import matrix_bank_pkg::*;
();

  localparam int          ROW_ALIGN = 64;
  localparam logic [31:0] SEED      = 32'h0793ade7;

  logic        core_clk = 1'b0;
  logic        resetn;
  logic        matrix_req_valid;
  logic        matrix_req_ready;
  matrix_req_t matrix_req;
  logic        matrix_resp_valid;
  logic        fetch_req_valid;
  logic        fetch_req_ready;
  fetch_req_t  fetch_req;
  logic        fetch_resp_valid;
  logic        fetch_resp_ready;
  beat_t       fetch_resp_data;
  logic        row_req_valid;
  logic        row_req_ready;
  logic        row_resp_valid;
  logic        row_resp_ready;
  row_resp_t   row_resp;

  // Test shapes
  int    cfg_rows  [2] = '{3, 8};
  int    cfg_cols  [2] = '{5, 16};
  addr_t cfg_start [2] = '{32'h1000, 32'h8000};

  // Current shape and its geometry
  int    cur_rows;
  int    cur_cols;
  int    cur_beats;
  int    cur_padded;
  addr_t cur_start;
  addr_t cur_stride;

  logic [31:0] rng;
  int          cycle;
  int          fetch_count;
  int          beats_seen;
  int          last_beat_cycle;
  int          load_pulses;
  int          resp_index;
  int          dumps_done;
  logic        req_held;
  fetch_req_t  held_req;
  logic        resp_held;
  row_resp_t   held_resp;
  row_resp_t   first_pass [$];

  matrix_bank #(.ROW_ALIGN_BYTES(ROW_ALIGN)) dut (.*);

  axi_read_model mem_model (.*);

  always #5 core_clk = ~core_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected memory word at a byte address
  function automatic feature_t pattern(input addr_t a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
  endfunction

  task automatic stop_on_error(input string msg);
    $display("error: %0t ns: %s", $time, msg);
    $display("Finished with errors");
    $fatal(1, "first error reached");
  endtask

  // ------------------------------
  // Checks on the row channel
  // ------------------------------

  task automatic check_response(input int i, input row_resp_t resp);
    logic in_mask;
    int   f;
    for (int r = 0; r < MAX_ROWS; r++) begin
      f       = i - r;
      in_mask = (r < cur_rows) && (f >= 0) && (f < cur_padded);
      assert (resp.valid_mask[r] == in_mask)
        else stop_on_error($sformatf("response %0d row %0d mask bit wrong", i, r));
      if (in_mask) begin
        assert (resp.data[r] == pattern(cur_start + cur_stride * addr_t'(r) + addr_t'(4 * f)))
          else stop_on_error($sformatf("response %0d row %0d data %h", i, r, resp.data[r]));
      end
    end
    assert (resp.done == (i == cur_rows + cur_padded - 1))
      else stop_on_error($sformatf("response %0d has done %0b", i, resp.done));
  endtask

  always @(posedge core_clk) begin
    if (!resetn) begin
      resp_held = 1'b0;
    end else begin
      if (resp_held) begin
        assert (row_resp_valid && row_resp == held_resp)
          else stop_on_error("row response changed while stalled");
      end
      if (row_resp_valid && row_resp_ready) begin
        check_response(resp_index, row_resp);
        if (dumps_done == 0) begin
          first_pass.push_back(row_resp);
        end else begin
          assert (first_pass[resp_index] == row_resp)
            else stop_on_error($sformatf("replay response %0d differs", resp_index));
        end
        if (row_resp.done) begin
          resp_index = 0;
          dumps_done++;
        end else begin
          resp_index++;
        end
      end
      resp_held = row_resp_valid && !row_resp_ready;
      held_resp = row_resp;
    end
  end

  // ------------------------------
  // Checks on the fetch side
  // ------------------------------

  always @(posedge core_clk) begin
    if (!resetn) begin
      req_held = 1'b0;
    end else begin
      if (req_held) begin
        assert (fetch_req_valid && fetch_req == held_req)
          else stop_on_error("fetch request changed before it was accepted");
      end
      if (fetch_req_valid && fetch_req_ready) begin
        assert (fetch_req.start_address == cur_start + cur_stride * addr_t'(fetch_count))
          else stop_on_error($sformatf("fetch %0d address %h", fetch_count,
                                       fetch_req.start_address));
        assert (fetch_req.byte_count == cur_cols * 4)
          else stop_on_error($sformatf("fetch byte count %0d", fetch_req.byte_count));
        fetch_count++;
        assert (fetch_count <= cur_rows) else stop_on_error("too many fetch requests");
      end
      if (fetch_resp_valid && fetch_resp_ready) begin
        beats_seen++;
        last_beat_cycle = cycle;
      end
      if (matrix_resp_valid) begin
        load_pulses++;
        assert (cycle == last_beat_cycle + BEAT_FEATURES)
          else stop_on_error($sformatf("load done at cycle %0d, last beat at cycle %0d",
                                       cycle, last_beat_cycle));
        assert (fetch_count == cur_rows && beats_seen == cur_rows * cur_beats)
          else stop_on_error($sformatf("load done after %0d fetches and %0d beats",
                                       fetch_count, beats_seen));
      end
      req_held = fetch_req_valid && !fetch_req_ready;
      held_req = fetch_req;
    end
    cycle++;
  end

  // Random back-pressure on the row channel
  always @(negedge core_clk) begin
    rng            = lcg_next(rng);
    row_resp_ready = rng[31] | rng[30];
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  task automatic apply_reset();
    @(negedge core_clk);
    resetn      = 1'b0;
    fetch_count = 0;
    beats_seen  = 0;
    load_pulses = 0;
    resp_index  = 0;
    dumps_done  = 0;
    first_pass.delete();
    repeat (8) @(negedge core_clk);
    resetn = 1'b1;
    @(posedge core_clk);
    assert (matrix_req_ready && !fetch_req_valid && !matrix_resp_valid &&
            !fetch_resp_ready && !row_req_ready && !row_resp_valid)
      else stop_on_error("handshake outputs wrong after reset");
  endtask

  task automatic load_matrix(input int rows, input int cols, input addr_t start);
    cur_rows   = rows;
    cur_cols   = cols;
    cur_start  = start;
    cur_beats  = (cols + BEAT_FEATURES - 1) / BEAT_FEATURES;
    cur_padded = cur_beats * BEAT_FEATURES;
    cur_stride = addr_t'((cols * 4 + ROW_ALIGN - 1) / ROW_ALIGN * ROW_ALIGN);
    @(negedge core_clk);
    matrix_req_valid         = 1'b1;
    matrix_req.start_address = start;
    matrix_req.columns       = dim_t'(cols);
    matrix_req.rows          = dim_t'(rows);
    do @(posedge core_clk); while (!matrix_req_ready);
    @(negedge core_clk);
    matrix_req_valid = 1'b0;
    do @(posedge core_clk); while (!matrix_resp_valid);
  endtask

  task automatic run_dump();
    int target;
    target = dumps_done + 1;
    @(negedge core_clk);
    row_req_valid = 1'b1;
    do @(posedge core_clk); while (!row_req_ready);
    @(negedge core_clk);
    row_req_valid = 1'b0;
    while (dumps_done < target) @(negedge core_clk);
  endtask

  initial begin
    resetn           = 1'b0;
    matrix_req_valid = 1'b0;
    matrix_req       = '0;
    row_req_valid    = 1'b0;
    row_resp_ready   = 1'b0;
    rng              = SEED;
    cycle            = 0;
    req_held         = 1'b0;
    resp_held        = 1'b0;
    for (int c = 0; c < 2; c++) begin
      apply_reset();
      load_matrix(cfg_rows[c], cfg_cols[c], cfg_start[c]);
      run_dump();
      run_dump();
      assert (load_pulses == 1)
        else stop_on_error($sformatf("%0d load done pulses", load_pulses));
    end
    $display("Finished with no errors");
    $finish;
  end

  // Budget per shape covers the fetch beats and two dumps
  initial begin
    int limit;
    limit = 200;
    for (int c = 0; c < 2; c++) begin
      limit += cfg_rows[c] * ((cfg_cols[c] + 3) / 4) * 20;
      limit += 4 * (cfg_rows[c] + (cfg_cols[c] + 3) / 4 * 4);
    end
    repeat (limit) @(posedge core_clk);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- flist.f
hdl/matrix_bank_pkg.sv
hdl/matrix_fetch_ctrl.sv
hdl/row_store.sv
hdl/diagonal_dump.sv
hdl/matrix_bank.sv
verification/axi_read_model.sv
verification/matrix_bank_tb.sv
